// ==== design/mem_perf_pkg.sv ====
package mem_perf_pkg;

    // Lane counts of the two cache ports.
    localparam int ICACHE_NUM_REQS = 1;
    localparam int DCACHE_NUM_REQS = 4;

    // Width of every running counter.
    localparam int PERF_CTR_BITS = 44;

    // Width of a per-cycle fire count on each port.
    localparam int ICACHE_CNT_BITS = $clog2(ICACHE_NUM_REQS + 1);
    localparam int DCACHE_CNT_BITS = $clog2(DCACHE_NUM_REQS + 1);

    typedef logic [PERF_CTR_BITS-1:0]   perf_ctr_t;
    typedef logic [ICACHE_NUM_REQS-1:0] icache_lanes_t;
    typedef logic [DCACHE_NUM_REQS-1:0] dcache_lanes_t;

    typedef logic [ICACHE_CNT_BITS-1:0] icache_cnt_t;
    typedef logic [DCACHE_CNT_BITS-1:0] dcache_cnt_t;

    // One cycle of handshake state seen on the instruction-cache port.
    typedef struct packed {
        icache_lanes_t req_valid;
        icache_lanes_t req_rw;
        icache_lanes_t req_ready;
        icache_lanes_t rsp_valid;
        icache_lanes_t rsp_ready;
    } icache_traffic_t;

    // Same for the data-cache port.
    typedef struct packed {
        dcache_lanes_t req_valid;
        dcache_lanes_t req_rw;
        dcache_lanes_t req_ready;
        dcache_lanes_t rsp_valid;
        dcache_lanes_t rsp_ready;
    } dcache_traffic_t;

    // Counter set visible at the top.
    typedef struct packed {
        perf_ctr_t ifetches;
        perf_ctr_t loads;
        perf_ctr_t stores;
        perf_ctr_t ifetch_latency;      // Sum of outstanding fetches per cycle.
        perf_ctr_t load_latency;        // Sum of outstanding loads per cycle.
    } mem_perf_t;

endpackage

// ==== design/traffic_sampler.sv ====
`timescale 1ns/1ps

module traffic_sampler #(
    parameter int NUM_LANES = 1
) (
    input  logic [NUM_LANES-1:0]           req_valid,
    input  logic [NUM_LANES-1:0]           req_rw,
    input  logic [NUM_LANES-1:0]           req_ready,
    input  logic [NUM_LANES-1:0]           rsp_valid,
    input  logic [NUM_LANES-1:0]           rsp_ready,

    output logic [$clog2(NUM_LANES+1)-1:0] rd_reqs,
    output logic [$clog2(NUM_LANES+1)-1:0] wr_reqs,
    output logic [$clog2(NUM_LANES+1)-1:0] rsps
);

    logic [NUM_LANES-1:0] rd_fire;
    logic [NUM_LANES-1:0] wr_fire;
    logic [NUM_LANES-1:0] rsp_fire;

    // Number of set bits in a lane mask.
    function automatic logic [$clog2(NUM_LANES+1)-1:0] pop_count(
        input logic [NUM_LANES-1:0] lanes
    );
        logic [$clog2(NUM_LANES+1)-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            cnt = cnt + $clog2(NUM_LANES+1)'(lanes[i]);
        end
        return cnt;
    endfunction

    // A lane fires when valid and ready meet in the same cycle.
    assign rd_fire  = req_valid & req_ready & ~req_rw;
    assign wr_fire  = req_valid & req_ready & req_rw;
    assign rsp_fire = rsp_valid & rsp_ready;       // Any response completes a read.

    always_comb begin
        rd_reqs = pop_count(rd_fire);
        wr_reqs = pop_count(wr_fire);
        rsps    = pop_count(rsp_fire);
    end

endmodule

// ==== design/traffic_accumulator.sv ====
`timescale 1ns/1ps

module traffic_accumulator #(
    parameter int NUM_LANES = 1
) (
    input  logic                           clk,
    input  logic                           reset,

    input  logic [$clog2(NUM_LANES+1)-1:0] rd_reqs,
    input  logic [$clog2(NUM_LANES+1)-1:0] wr_reqs,
    input  logic [$clog2(NUM_LANES+1)-1:0] rsps,

    output mem_perf_pkg::perf_ctr_t        reads,
    output mem_perf_pkg::perf_ctr_t        writes,
    output mem_perf_pkg::perf_ctr_t        latency
);
    import mem_perf_pkg::*;

    // One extra bit so the difference keeps its sign.
    logic signed [$clog2(NUM_LANES+1):0] pending_delta;

    // Reads in flight, two's complement and free to wrap.
    perf_ctr_t outstanding;

    assign pending_delta = $signed({1'b0, rd_reqs}) - $signed({1'b0, rsps});

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + PERF_CTR_BITS'(pending_delta); // Sign-extended.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reads   <= '0;
            writes  <= '0;
            latency <= '0;
        end else begin
            reads   <= reads + PERF_CTR_BITS'(rd_reqs);
            writes  <= writes + PERF_CTR_BITS'(wr_reqs);
            // Count as it stood before this edge.
            latency <= latency + outstanding;
        end
    end

endmodule

// ==== design/core_mem_perf.sv ====
`timescale 1ns/1ps

module core_mem_perf (
    input  logic                        clk,
    input  logic                        reset,

    input  mem_perf_pkg::icache_lanes_t icache_req_valid,
    input  mem_perf_pkg::icache_lanes_t icache_req_rw,
    input  mem_perf_pkg::icache_lanes_t icache_req_ready,
    input  mem_perf_pkg::icache_lanes_t icache_rsp_valid,
    input  mem_perf_pkg::icache_lanes_t icache_rsp_ready,

    input  mem_perf_pkg::dcache_lanes_t dcache_req_valid,
    input  mem_perf_pkg::dcache_lanes_t dcache_req_rw,
    input  mem_perf_pkg::dcache_lanes_t dcache_req_ready,
    input  mem_perf_pkg::dcache_lanes_t dcache_rsp_valid,
    input  mem_perf_pkg::dcache_lanes_t dcache_rsp_ready,

    output mem_perf_pkg::mem_perf_t     perf
);
    import mem_perf_pkg::*;

    icache_traffic_t icache_traffic;
    dcache_traffic_t dcache_traffic;

    icache_cnt_t icache_rd_reqs;
    icache_cnt_t icache_wr_reqs;
    icache_cnt_t icache_rsps;

    dcache_cnt_t dcache_rd_reqs;
    dcache_cnt_t dcache_wr_reqs;
    dcache_cnt_t dcache_rsps;

    perf_ctr_t ifetches;
    perf_ctr_t ifetch_latency;
    perf_ctr_t loads;
    perf_ctr_t stores;
    perf_ctr_t load_latency;

    assign icache_traffic.req_valid = icache_req_valid;
    assign icache_traffic.req_rw    = icache_req_rw;
    assign icache_traffic.req_ready = icache_req_ready;
    assign icache_traffic.rsp_valid = icache_rsp_valid;
    assign icache_traffic.rsp_ready = icache_rsp_ready;

    assign dcache_traffic.req_valid = dcache_req_valid;
    assign dcache_traffic.req_rw    = dcache_req_rw;
    assign dcache_traffic.req_ready = dcache_req_ready;
    assign dcache_traffic.rsp_valid = dcache_rsp_valid;
    assign dcache_traffic.rsp_ready = dcache_rsp_ready;

    traffic_sampler #(
        .NUM_LANES (ICACHE_NUM_REQS)
    ) icache_sampler (
        .req_valid (icache_traffic.req_valid),
        .req_rw    (icache_traffic.req_rw),
        .req_ready (icache_traffic.req_ready),
        .rsp_valid (icache_traffic.rsp_valid),
        .rsp_ready (icache_traffic.rsp_ready),
        .rd_reqs   (icache_rd_reqs),
        .wr_reqs   (icache_wr_reqs),
        .rsps      (icache_rsps)
    );

    traffic_sampler #(
        .NUM_LANES (DCACHE_NUM_REQS)
    ) dcache_sampler (
        .req_valid (dcache_traffic.req_valid),
        .req_rw    (dcache_traffic.req_rw),
        .req_ready (dcache_traffic.req_ready),
        .rsp_valid (dcache_traffic.rsp_valid),
        .rsp_ready (dcache_traffic.rsp_ready),
        .rd_reqs   (dcache_rd_reqs),
        .wr_reqs   (dcache_wr_reqs),
        .rsps      (dcache_rsps)
    );

    traffic_accumulator #(
        .NUM_LANES (ICACHE_NUM_REQS)
    ) icache_acc (
        .clk       (clk),
        .reset     (reset),
        .rd_reqs   (icache_rd_reqs),
        .wr_reqs   (icache_wr_reqs),
        .rsps      (icache_rsps),
        .reads     (ifetches),
        .writes    (),                  // Instruction writes are not reported.
        .latency   (ifetch_latency)
    );

    traffic_accumulator #(
        .NUM_LANES (DCACHE_NUM_REQS)
    ) dcache_acc (
        .clk       (clk),
        .reset     (reset),
        .rd_reqs   (dcache_rd_reqs),
        .wr_reqs   (dcache_wr_reqs),
        .rsps      (dcache_rsps),
        .reads     (loads),
        .writes    (stores),
        .latency   (load_latency)
    );

    assign perf.ifetches       = ifetches;
    assign perf.loads          = loads;
    assign perf.stores         = stores;
    assign perf.ifetch_latency = ifetch_latency;
    assign perf.load_latency   = load_latency;

endmodule

// ==== bench/core_mem_perf_checker.sv ====
`timescale 1ns/1ps

module core_mem_perf_checker (
    input logic                        clk,
    input logic                        reset,
    input mem_perf_pkg::dcache_lanes_t dcache_rsp_valid,
    input mem_perf_pkg::dcache_lanes_t dcache_rsp_ready,
    input mem_perf_pkg::mem_perf_t     perf
);
    import mem_perf_pkg::*;

    perf_ctr_t rsp_total;
    perf_ctr_t dc_outstanding;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_total <= '0;
        end else begin
            rsp_total <= rsp_total + perf_ctr_t'($countones(dcache_rsp_valid & dcache_rsp_ready));
        end
    end

    // Loads issued minus responses seen.
    assign dc_outstanding = perf.loads - rsp_total;

    zero_after_reset: assert property (@(posedge clk) reset |=> perf == '0)
        else $error("perf not cleared one cycle after reset");

    ifetches_monotonic: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> perf.ifetches >= $past(perf.ifetches))
        else $error("ifetches decreased");

    loads_monotonic: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> perf.loads >= $past(perf.loads))
        else $error("loads decreased");

    stores_monotonic: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> perf.stores >= $past(perf.stores))
        else $error("stores decreased");

    load_latency_monotonic: assert property (@(posedge clk) disable iff (reset)
        !dc_outstanding[PERF_CTR_BITS-1] |=> perf.load_latency >= $past(perf.load_latency))
        else $error("load_latency decreased with non-negative outstanding loads");

endmodule

bind core_mem_perf core_mem_perf_checker perf_checker (
    .clk              (clk),
    .reset            (reset),
    .dcache_rsp_valid (dcache_rsp_valid),
    .dcache_rsp_ready (dcache_rsp_ready),
    .perf             (perf)
);

// ==== bench/core_mem_perf_tb.sv ====
`timescale 1ns/1ps

module core_mem_perf_tb;
    import mem_perf_pkg::*;

    localparam int CLK_HALF        = 50;
    localparam int DRIVE_DELAY     = 5;
    localparam int RESET_CYCLES    = 3;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int DRAIN_TIMEOUT   = 500;
    localparam int WATCHDOG_CYCLES = 20000;

    // Expected counters plus reads in flight on each port.
    typedef struct packed {
        mem_perf_t perf;
        perf_ctr_t ic_outstanding;
        perf_ctr_t dc_outstanding;
    } model_t;

    logic            clk;
    logic            reset;
    icache_traffic_t ic_drv;
    dcache_traffic_t dc_drv;
    mem_perf_t       perf;
    model_t          model;

    int errors = 0;
    int checks = 0;
    int tests  = 0;

    core_mem_perf uut (
        .clk              (clk),
        .reset            (reset),
        .icache_req_valid (ic_drv.req_valid),
        .icache_req_rw    (ic_drv.req_rw),
        .icache_req_ready (ic_drv.req_ready),
        .icache_rsp_valid (ic_drv.rsp_valid),
        .icache_rsp_ready (ic_drv.rsp_ready),
        .dcache_req_valid (dc_drv.req_valid),
        .dcache_req_rw    (dc_drv.req_rw),
        .dcache_req_ready (dc_drv.req_ready),
        .dcache_rsp_valid (dc_drv.rsp_valid),
        .dcache_rsp_ready (dc_drv.rsp_ready),
        .perf             (perf)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic perf_ctr_t fire_count(input dcache_lanes_t lanes);
        perf_ctr_t n;
        n = '0;
        for (int i = 0; i < DCACHE_NUM_REQS; i++) begin
            if (lanes[i]) begin
                n = n + perf_ctr_t'(1);
            end
        end
        return n;
    endfunction

    // Next counter state from one sampled cycle of handshakes.
    function automatic model_t predict_next(input model_t s, input icache_traffic_t ic,
                                            input dcache_traffic_t dc);
        model_t    n;
        perf_ctr_t ic_rd;
        perf_ctr_t ic_rsp;
        perf_ctr_t dc_rd;
        perf_ctr_t dc_wr;
        perf_ctr_t dc_rsp;
        ic_rd  = fire_count(dcache_lanes_t'(ic.req_valid & ic.req_ready & ~ic.req_rw));
        ic_rsp = fire_count(dcache_lanes_t'(ic.rsp_valid & ic.rsp_ready));
        dc_rd  = fire_count(dc.req_valid & dc.req_ready & ~dc.req_rw);
        dc_wr  = fire_count(dc.req_valid & dc.req_ready & dc.req_rw);
        dc_rsp = fire_count(dc.rsp_valid & dc.rsp_ready);
        n = s;
        n.perf.ifetches       = s.perf.ifetches + ic_rd;
        n.perf.loads          = s.perf.loads + dc_rd;
        n.perf.stores         = s.perf.stores + dc_wr;
        n.perf.ifetch_latency = s.perf.ifetch_latency + s.ic_outstanding;  // Pre-edge count.
        n.perf.load_latency   = s.perf.load_latency + s.dc_outstanding;
        n.ic_outstanding      = s.ic_outstanding + ic_rd - ic_rsp;
        n.dc_outstanding      = s.dc_outstanding + dc_rd - dc_rsp;
        return n;
    endfunction

    function automatic int clamp_lanes(input perf_ctr_t outstanding, input int lanes);
        if (outstanding >= perf_ctr_t'(lanes)) begin
            return lanes;
        end
        return int'(outstanding);
    endfunction

    // Lowest k lanes set.
    function automatic dcache_lanes_t low_lanes(input int k);
        dcache_lanes_t lanes;
        for (int i = 0; i < DCACHE_NUM_REQS; i++) begin
            lanes[i] = (i < k);
        end
        return lanes;
    endfunction

    task automatic check_perf(input mem_perf_t got, input mem_perf_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d/%0d/%0d/%0d/%0d exp %0d/%0d/%0d/%0d/%0d",
                     $time, what, got.ifetches, got.loads, got.stores, got.ifetch_latency,
                     got.load_latency, exp.ifetches, exp.loads, exp.stores,
                     exp.ifetch_latency, exp.load_latency);
        end
    endtask

    task automatic check_ctr(input string name, input perf_ctr_t got, input perf_ctr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int mark);
        tests++;
        if (errors == mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - mark);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic apply_traffic(input icache_traffic_t ic, input dcache_traffic_t dc);
        step();
        ic_drv = ic;
        dc_drv = dc;
    endtask

    // Fire responses until the model shows no reads in flight.
    task automatic drain_outstanding(input string name);
        int cycles;
        cycles = 0;
        step();
        while (model.ic_outstanding != '0 || model.dc_outstanding != '0) begin
            if (cycles == DRAIN_TIMEOUT) begin
                $display("Timeout: %s reads still outstanding after %0d cycles",
                         name, DRAIN_TIMEOUT);
                errors++;
                break;
            end
            ic_drv = '0;
            dc_drv = '0;
            ic_drv.rsp_valid = icache_lanes_t'(low_lanes(
                clamp_lanes(model.ic_outstanding, ICACHE_NUM_REQS)));
            ic_drv.rsp_ready = ic_drv.rsp_valid;
            dc_drv.rsp_valid = low_lanes(clamp_lanes(model.dc_outstanding, DCACHE_NUM_REQS));
            dc_drv.rsp_ready = dc_drv.rsp_valid;
            cycles++;
            step();
        end
        ic_drv = '0;
        dc_drv = '0;
    endtask

    // One read on lane 0 whose response waits k-1 cycles before it fires.
    task automatic latency_probe(input bit on_icache, input int k);
        icache_traffic_t ic;
        dcache_traffic_t dc;
        perf_ctr_t       base;
        base = on_icache ? model.perf.ifetch_latency : model.perf.load_latency;
        ic = '0;
        dc = '0;
        if (on_icache) begin
            ic.req_valid = '1;
            ic.req_ready = '1;
        end else begin
            dc.req_valid[0] = 1'b1;
            dc.req_ready[0] = 1'b1;
        end
        apply_traffic(ic, dc);
        ic = '0;
        dc = '0;
        if (on_icache) begin
            ic.rsp_valid = '1;
        end else begin
            dc.rsp_valid[0] = 1'b1;
        end
        repeat (k - 1) apply_traffic(ic, dc);
        if (on_icache) begin
            ic.rsp_ready = '1;
        end else begin
            dc.rsp_ready[0] = 1'b1;
        end
        apply_traffic(ic, dc);
        apply_traffic('0, '0);
        if (on_icache) begin
            check_ctr("ifetch_latency", perf.ifetch_latency, base + perf_ctr_t'(k));
        end else begin
            check_ctr("load_latency", perf.load_latency, base + perf_ctr_t'(k));
        end
    endtask

    // Responses only while reads are in flight, so counts never go negative.
    task automatic random_traffic(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            step();
            ic_drv.req_valid = icache_lanes_t'($urandom);
            ic_drv.req_rw    = icache_lanes_t'($urandom);
            ic_drv.req_ready = icache_lanes_t'($urandom);
            ic_drv.rsp_valid = icache_lanes_t'($urandom) & icache_lanes_t'(low_lanes(
                clamp_lanes(model.ic_outstanding, ICACHE_NUM_REQS)));
            ic_drv.rsp_ready = icache_lanes_t'($urandom);
            dc_drv.req_valid = dcache_lanes_t'($urandom);
            dc_drv.req_rw    = dcache_lanes_t'($urandom);
            dc_drv.req_ready = dcache_lanes_t'($urandom);
            dc_drv.rsp_valid = dcache_lanes_t'($urandom)
                & low_lanes(clamp_lanes(model.dc_outstanding, DCACHE_NUM_REQS));
            dc_drv.rsp_ready = dcache_lanes_t'($urandom);
        end
    endtask

    initial begin
        model = '0;
        forever begin
            @(posedge clk);
            if (reset) begin
                model = '0;
            end else begin
                model = predict_next(model, ic_drv, dc_drv);
            end
            #1;
            check_perf(perf, model.perf, "counters vs model");
        end
    end

    initial begin
        for (int c = 0; c < WATCHDOG_CYCLES; c++) begin
            @(posedge clk);
        end
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int              mark;
        perf_ctr_t       base;
        icache_traffic_t ic;
        dcache_traffic_t dc;
        void'($urandom(32'h500e));
        reset  = 1'b1;
        ic_drv = '0;
        dc_drv = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        mark = errors;
        repeat (5) begin
            apply_traffic('0, '0);
            check_perf(perf, '0, "idle after reset");
        end
        finish_test("idle after reset", mark);

        mark = errors;
        base = model.perf.ifetches;
        ic = '0;
        ic.req_valid = '1;
        for (int i = 0; i < 14; i++) begin
            ic.req_ready = icache_lanes_t'(i % 2 == 0);  // Every other cycle stalls.
            apply_traffic(ic, '0);
        end
        apply_traffic('0, '0);
        check_ctr("ifetches", perf.ifetches, base + perf_ctr_t'(7));
        drain_outstanding("fetch");
        finish_test("instruction fetches", mark);

        mark = errors;
        for (int i = 0; i < 50; i++) begin
            dc = '0;
            dc.req_valid = dcache_lanes_t'($urandom);
            dc.req_rw    = dcache_lanes_t'($urandom);
            dc.req_ready = dcache_lanes_t'($urandom);
            apply_traffic('0, dc);
        end
        apply_traffic('0, '0);
        check_ctr("loads", perf.loads, model.perf.loads);
        check_ctr("stores", perf.stores, model.perf.stores);
        drain_outstanding("load");
        finish_test("loads and stores", mark);

        mark = errors;
        for (int k = 1; k <= 6; k++) begin
            latency_probe(1'b0, k);
            latency_probe(1'b1, k);
        end
        finish_test("single read latency", mark);

        mark = errors;
        random_traffic(RANDOM_CYCLES);
        apply_traffic('0, '0);
        check_perf(perf, model.perf, "after random traffic");
        drain_outstanding("random");
        finish_test("random traffic", mark);

        mark = errors;
        random_traffic(20);
        step();
        reset  = 1'b1;
        ic_drv = '0;
        dc_drv = '0;
        repeat (RESET_CYCLES) step();
        reset = 1'b0;
        check_perf(perf, '0, "mid-run reset");
        ic = '0;
        ic.req_valid = '1;
        ic.req_ready = '1;
        dc = '0;
        dc.req_valid = low_lanes(2);
        dc.req_ready = low_lanes(2);
        repeat (3) apply_traffic(ic, dc);
        apply_traffic('0, '0);
        check_ctr("ifetches", perf.ifetches, perf_ctr_t'(3));
        check_ctr("loads", perf.loads, perf_ctr_t'(6));
        check_ctr("stores", perf.stores, perf_ctr_t'(0));
        finish_test("mid-run reset", mark);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
design/mem_perf_pkg.sv
design/traffic_sampler.sv
design/traffic_accumulator.sv
design/core_mem_perf.sv
bench/core_mem_perf_checker.sv
bench/core_mem_perf_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory-traffic performance monitor.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= core_mem_perf_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) || echo "Result: FAILED" >> $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
